// ==== logic/secded_pkg.sv ====
// Inverted 72/64 SECDED code constants
`default_nettype none

package secded_pkg;

  // Payload, check and stored code word widths.
  localparam int DataWidth = 64;
  localparam int EccWidth  = 8;
  localparam int CodeWidth = DataWidth + EccWidth;

  typedef logic [EccWidth-1:0][DataWidth-1:0] ecc_masks_t;

  // Builds the check matrix column by column.
  // Only 56 weight-3 columns exist in 8 bits, so the last eight data bits take weight-5 columns.
  // All columns stay odd and distinct, which keeps double errors apart from single ones.
  function automatic ecc_masks_t gen_ecc_masks();
    ecc_masks_t          masks;
    int unsigned         col_idx;
    logic [EccWidth-1:0] col;
    masks   = '0;
    col_idx = 0;
    for (int weight = 3; weight <= 5; weight += 2) begin
      for (int val = 0; val < 2**EccWidth; val++) begin
        col = val[EccWidth-1:0];
        // Take the next free column of the wanted weight.
        if (($countones(col) == weight) && (col_idx < DataWidth)) begin
          for (int j = 0; j < EccWidth; j++) begin
            masks[j][col_idx] = col[j];
          end
          col_idx++;
        end
      end
    end
    return masks;
  endfunction

  // Check bit j is the even parity of data & EccMasks[j].
  localparam ecc_masks_t EccMasks = gen_ecc_masks();

  // XORed onto the check bits, so an all-zero code word never decodes clean.
  localparam logic [EccWidth-1:0] EccInv = 8'hAA;

  // Check bits of an all-zero data word.
  localparam logic [EccWidth-1:0] ZeroEcc = EccInv;

endpackage

`default_nettype wire

// ==== logic/otp_part_pkg.sv ====
// OTP partition parameters
`default_nettype none

package otp_part_pkg;

  // Number of 64-bit words in the partition.
  localparam int PartDepth = 8;

  // Word address width.
  localparam int PartAw = 3;

  // Loader states.
  // Done and Error are terminal until reset.
  typedef enum logic [2:0] {
    Idle,
    Req,
    Wait,
    Done,
    Error
  } loader_state_e;

endpackage

`default_nettype wire

// ==== logic/secded_enc.sv ====
// SECDED 72/64 encoder
`default_nettype none

module secded_enc import secded_pkg::*; (
  input  logic [DataWidth-1:0] data_i,
  output logic [EccWidth-1:0]  ecc_o
);

  logic [EccWidth-1:0] parity;

  // One parity tree per check bit.
  always_comb begin : p_parity
    for (int j = 0; j < EccWidth; j++) begin
      parity[j] = ^(data_i & EccMasks[j]);
    end
  end

  // Inversion makes the zero word invalid.
  assign ecc_o = parity ^ EccInv;

endmodule

`default_nettype wire

// ==== logic/secded_dec.sv ====
// SECDED 72/64 decoder
`default_nettype none

module secded_dec import secded_pkg::*; (
  input  logic [DataWidth-1:0] data_i,
  input  logic [EccWidth-1:0]  ecc_i,
  output logic [DataWidth-1:0] data_o,
  // Bit 0 is a corrected single error, bit 1 an uncorrectable one.
  output logic [1:0]           err_o
);

  logic [EccWidth-1:0]  ecc_calc;
  logic [EccWidth-1:0]  syndrome;
  logic [DataWidth-1:0] flip;
  logic                 single_err;

  // Re-encode the received data.
  // The inversion cancels against the stored check bits.
  secded_enc u_enc (
    .data_i(data_i),
    .ecc_o (ecc_calc)
  );

  assign syndrome = ecc_calc ^ ecc_i;

  // Match the syndrome against every data column.
  always_comb begin : p_flip
    logic [EccWidth-1:0] col;
    col = '0;
    for (int i = 0; i < DataWidth; i++) begin
      for (int j = 0; j < EccWidth; j++) begin
        col[j] = EccMasks[j][i];
      end
      flip[i] = (syndrome == col);
    end
  end

  // At most one bit of flip can be set, since all columns are distinct.
  assign data_o = data_i ^ flip;

  // A one-hot syndrome points at a check bit; the data passes unchanged.
  assign single_err = (|flip) | $onehot(syndrome);

  assign err_o[0] = single_err;
  // Any other nonzero syndrome has even weight or no matching column.
  assign err_o[1] = (|syndrome) & ~single_err;

endmodule

`default_nettype wire

// ==== logic/otp_ecc_reg.sv ====
// ECC-protected partition buffer
`default_nettype none

module otp_ecc_reg
  import secded_pkg::*;
  import otp_part_pkg::*;
#(
  parameter  int Depth = PartDepth,
  // Index bits for the stored words.
  localparam int IdxW  = (Depth > 1) ? $clog2(Depth) : 1,
  // One extra address bit, so addresses past the end can be requested.
  localparam int Aw    = IdxW + 1
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            wren_i,
  input  logic [Aw-1:0]                   addr_i,
  input  logic [DataWidth-1:0]            wdata_i,
  output logic [DataWidth-1:0]            rdata_o,
  output logic [Depth-1:0][DataWidth-1:0] data_o,
  output logic                            ecc_err_o
);

  logic [Depth-1:0][DataWidth-1:0] data_q;
  logic [Depth-1:0][EccWidth-1:0]  ecc_q;
  logic [EccWidth-1:0]             ecc_enc;
  logic                            addr_ok;
  logic [Depth-1:0][1:0]           err;

  // A single encoder serves the write port.
  secded_enc u_enc (
    .data_i(wdata_i),
    .ecc_o (ecc_enc)
  );

  assign addr_ok = (int'(addr_i) < Depth);

  // Out of range reads return zero.
  assign rdata_o = addr_ok ? data_q[addr_i[IdxW-1:0]] : '0;

  assign data_o = data_q;

  // Write data and check bits together.
  // Reset leaves a valid all-zero code word in every entry.
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      data_q <= '0;
      ecc_q  <= {Depth{ZeroEcc}};
    end else if (wren_i && addr_ok) begin
      data_q[addr_i[IdxW-1:0]] <= wdata_i;
      ecc_q[addr_i[IdxW-1:0]]  <= ecc_enc;
    end
  end

  // Concurrent check of every stored word, every cycle.
  // Only detection is used here, not correction.
  for (genvar k = 0; k < Depth; k++) begin : gen_dec
    secded_dec u_dec (
      .data_i(data_q[k]),
      .ecc_i (ecc_q[k]),
      .data_o(),
      .err_o (err[k])
    );
  end

  // Any single or double error in the buffer is flagged.
  assign ecc_err_o = |err;

endmodule

`default_nettype wire

// ==== logic/part_loader.sv ====
// OTP partition loader
`default_nettype none

module part_loader
  import secded_pkg::*;
  import otp_part_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 init_i,
  // OTP macro port.
  output logic                 otp_req_o,
  output logic [PartAw-1:0]    otp_addr_o,
  input  logic                 otp_valid_i,
  input  logic [DataWidth-1:0] otp_data_i,
  input  logic [EccWidth-1:0]  otp_ecc_i,
  // Buffer write port.
  output logic                 buf_we_o,
  output logic [PartAw-1:0]    buf_addr_o,
  output logic [DataWidth-1:0] buf_wdata_o,
  // Status.
  output logic                 done_o,
  output logic                 corr_o,
  output logic                 err_o
);

  loader_state_e        state_d, state_q;
  logic [PartAw-1:0]    addr_d, addr_q;
  logic                 corr_d, corr_q;
  logic [DataWidth-1:0] dec_data;
  logic [1:0]           dec_err;
  logic                 last_word;

  // Check and correct the incoming word.
  secded_dec u_dec (
    .data_i(otp_data_i),
    .ecc_i (otp_ecc_i),
    .data_o(dec_data),
    .err_o (dec_err)
  );

  assign last_word = (addr_q == PartAw'(PartDepth - 1));

  always_comb begin : p_fsm
    state_d  = state_q;
    addr_d   = addr_q;
    corr_d   = corr_q;
    buf_we_o = 1'b0;
    unique case (state_q)
      Idle: begin
        // Start from word 0 on init.
        if (init_i) begin
          addr_d  = '0;
          state_d = Req;
        end
      end
      // Strobe lasts exactly one cycle.
      Req: begin
        state_d = Wait;
      end
      Wait: begin
        if (otp_valid_i) begin
          if (dec_err[1]) begin
            // Uncorrectable, nothing is written.
            state_d = Error;
          end else begin
            buf_we_o = 1'b1;
            corr_d   = corr_q | dec_err[0];
            if (last_word) begin
              state_d = Done;
            end else begin
              addr_d  = addr_q + 1'b1;
              state_d = Req;
            end
          end
        end
      end
      // Terminal states, left only by reset.
      Done, Error: begin
        state_d = state_q;
      end
      default: begin
        state_d = Error;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q <= Idle;
      addr_q  <= '0;
      corr_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      corr_q  <= corr_d;
    end
  end

  // Address is held from the request up to its valid.
  assign otp_req_o   = (state_q == Req);
  assign otp_addr_o  = addr_q;
  assign buf_addr_o  = addr_q;
  assign buf_wdata_o = dec_data;

  assign done_o = (state_q == Done);
  assign err_o  = (state_q == Error);
  assign corr_o = corr_q;

endmodule

`default_nettype wire

// ==== logic/part_buf.sv ====
// Buffered OTP partition
`default_nettype none

module part_buf
  import secded_pkg::*;
  import otp_part_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                init_i,
  // OTP macro port.
  output logic                                otp_req_o,
  output logic [PartAw-1:0]                   otp_addr_o,
  input  logic                                otp_valid_i,
  input  logic [DataWidth-1:0]                otp_data_i,
  input  logic [EccWidth-1:0]                 otp_ecc_i,
  // Host read port, one bit wider than the word index.
  input  logic [PartAw:0]                     rd_addr_i,
  output logic [DataWidth-1:0]                rd_data_o,
  // Whole partition in parallel.
  output logic [PartDepth-1:0][DataWidth-1:0] part_data_o,
  // Status.
  output logic                                done_o,
  output logic                                corr_o,
  output logic                                fatal_o
);

  logic                 buf_we;
  logic [PartAw-1:0]    buf_addr;
  logic [DataWidth-1:0] buf_wdata;
  logic [PartAw:0]      mem_addr;
  logic                 loader_err;
  logic                 ecc_err;

  part_loader u_loader (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .init_i     (init_i),
    .otp_req_o  (otp_req_o),
    .otp_addr_o (otp_addr_o),
    .otp_valid_i(otp_valid_i),
    .otp_data_i (otp_data_i),
    .otp_ecc_i  (otp_ecc_i),
    .buf_we_o   (buf_we),
    .buf_addr_o (buf_addr),
    .buf_wdata_o(buf_wdata),
    .done_o     (done_o),
    .corr_o     (corr_o),
    .err_o      (loader_err)
  );

  // Single buffer address, the loader takes it in its write cycles.
  assign mem_addr = buf_we ? {1'b0, buf_addr} : rd_addr_i;

  otp_ecc_reg #(
    .Depth(PartDepth)
  ) u_ecc_reg (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wren_i   (buf_we),
    .addr_i   (mem_addr),
    .wdata_i  (buf_wdata),
    .rdata_o  (rd_data_o),
    .data_o   (part_data_o),
    .ecc_err_o(ecc_err)
  );

  // OTP or buffer integrity failure.
  assign fatal_o = loader_err | ecc_err;

endmodule

`default_nettype wire

// ==== tests/part_buf_tb.sv ====
// Buffered OTP partition testbench
`default_nettype none

module part_buf_tb
  import secded_pkg::*;
  import otp_part_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  // Words per run as stored in the OTP before any bit flips.
  localparam logic [DataWidth-1:0] WordTab [2][PartDepth] = '{
    '{64'h0123_4567_89AB_CDEF, 64'hFEDC_BA98_7654_3210, 64'h0000_0000_0000_0000,
      64'hFFFF_FFFF_FFFF_FFFF, 64'hDEAD_BEEF_CAFE_F00D, 64'h5555_AAAA_3333_CCCC,
      64'h0F0F_F0F0_00FF_FF00, 64'h8000_0000_0000_0001},
    '{64'h1357_9BDF_2468_ACE0, 64'hA5A5_5A5A_0000_FFFF, 64'h7777_8888_9999_AAAA,
      64'hC0DE_0000_1234_5678, 64'h0000_0001_0000_0001, 64'hBAD0_BAD0_BAD0_BAD0,
      64'h3C3C_3C3C_C3C3_C3C3, 64'hFFFF_0000_FFFF_0000}
  };

  // Flip masks over {ecc, data}; bits 71:64 hit the check bits.
  localparam logic [CodeWidth-1:0] FlipTab [2][PartDepth] = '{
    '{72'h00_0000_0000_0000_0000, 72'h00_0000_0000_0000_0008, 72'h00_0000_0000_0000_0000,
      72'h04_0000_0000_0000_0000, 72'h00_8000_0000_0000_0000, 72'h00_0000_0000_0000_0000,
      72'h80_0000_0000_0000_0000, 72'h00_0000_0100_0000_0000},
    '{72'h00_0000_0000_0000_0000, 72'h00_0000_0000_0000_0000, 72'h40_0000_0000_0000_0000,
      72'h00_0000_0000_0000_0000, 72'h00_0000_0000_0000_0000, 72'h00_0000_0000_0010_0400,
      72'h00_0000_0000_0000_0001, 72'h00_0000_0000_0000_0000}
  };

  logic                                clk_i;
  logic                                rst_ni;
  logic                                init_i;
  logic                                otp_req_o;
  logic [PartAw-1:0]                   otp_addr_o;
  logic                                otp_valid_i;
  logic [DataWidth-1:0]                otp_data_i;
  logic [EccWidth-1:0]                 otp_ecc_i;
  logic [PartAw:0]                     rd_addr_i;
  logic [DataWidth-1:0]                rd_data_o;
  logic [PartDepth-1:0][DataWidth-1:0] part_data_o;
  logic                                done_o;
  logic                                corr_o;
  logic                                fatal_o;

  // OTP model state.
  int                run;
  int                wait_cnt;
  int                req_count;
  logic [PartAw-1:0] req_addr;
  logic [7:0]        lfsr_q;

  part_buf uut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .init_i     (init_i),
    .otp_req_o  (otp_req_o),
    .otp_addr_o (otp_addr_o),
    .otp_valid_i(otp_valid_i),
    .otp_data_i (otp_data_i),
    .otp_ecc_i  (otp_ecc_i),
    .rd_addr_i  (rd_addr_i),
    .rd_data_o  (rd_data_o),
    .part_data_o(part_data_o),
    .done_o     (done_o),
    .corr_o     (corr_o),
    .fatal_o    (fatal_o)
  );

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [63:0] exp, input logic [63:0] got);
    assert (got === exp) else
      fail_now($sformatf("[FAIL] %0t: %s expected %h, got %h", $time, name, exp, got));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    assert (got === exp) else
      fail_now($sformatf("[FAIL] %0t: %s expected %b, got %b", $time, name, exp, got));
  endtask

  // Check bits by masked parity followed by inversion.
  function automatic logic [EccWidth-1:0] encode(input logic [DataWidth-1:0] d);
    logic [EccWidth-1:0] e;
    for (int j = 0; j < EccWidth; j++) begin
      e[j] = ^(d & EccMasks[j]);
    end
    return e ^ EccInv;
  endfunction

  // Galois LFSR with polynomial x^8 + x^6 + x^5 + x^4 + 1.
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  task automatic draw_bit(output logic b);
    b      = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  endtask

  // First word with two or more flips stops the load.
  function automatic int fault_index(input int r);
    for (int i = 0; i < PartDepth; i++) begin
      if ($countones(FlipTab[r][i]) >= 2) return i;
    end
    return PartDepth;
  endfunction

  // Sticky corrected flag from single flips before the fault.
  function automatic logic expect_corr(input int r);
    for (int i = 0; i < fault_index(r); i++) begin
      if ($countones(FlipTab[r][i]) == 1) return 1'b1;
    end
    return 1'b0;
  endfunction

  // Expected buffer word, zero from the faulty word on and past the end.
  function automatic logic [63:0] expect_word(input int r, input int a);
    if (a >= PartDepth || a >= fault_index(r)) return '0;
    return WordTab[r][a];
  endfunction

  // OTP macro model answering each request once, 1 to 4 cycles later.
  initial begin : otp_model
    logic                 b0;
    logic                 b1;
    logic [CodeWidth-1:0] flip;
    otp_valid_i = 1'b0;
    otp_data_i  = '0;
    otp_ecc_i   = '0;
    lfsr_q      = 8'd21;
    wait_cnt    = 0;
    req_count   = 0;
    req_addr    = '0;
    forever begin
      @(posedge clk_i);
      #2;
      otp_valid_i = 1'b0;
      if (!rst_ni) begin
        wait_cnt  = 0;
        req_count = 0;
      end else begin
        if (wait_cnt > 0) begin
          wait_cnt--;
          if (wait_cnt == 0) begin
            // Address must still be the requested one.
            check_word("otp_addr_o", 64'(req_addr), 64'(otp_addr_o));
            flip        = FlipTab[run][req_addr];
            otp_data_i  = WordTab[run][req_addr] ^ flip[DataWidth-1:0];
            otp_ecc_i   = encode(WordTab[run][req_addr]) ^ flip[CodeWidth-1:DataWidth];
            otp_valid_i = 1'b1;
          end
        end
        if (otp_req_o) begin
          assert (wait_cnt == 0) else
            fail_now("OTP request issued while a read was still pending");
          // Words are fetched in address order from word 0.
          check_word("otp_addr_o", 64'(req_count), 64'(otp_addr_o));
          draw_bit(b0);
          draw_bit(b1);
          req_addr = otp_addr_o;
          wait_cnt = 1 + int'({b1, b0});
          req_count++;
        end
      end
    end
  end

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
  endtask

  // One host read per cycle.
  task automatic compare_read(input int a, input logic [63:0] exp);
    @(posedge clk_i);
    #2;
    rd_addr_i = (PartAw + 1)'(a);
    #1;
    check_word($sformatf("rd_data_o[%0d]", a), exp, rd_data_o);
  endtask

  // Status low and every address reads zero.
  task automatic check_reset_state();
    check_bit("done_o", 1'b0, done_o);
    check_bit("corr_o", 1'b0, corr_o);
    check_bit("fatal_o", 1'b0, fatal_o);
    check_bit("otp_req_o", 1'b0, otp_req_o);
    for (int a = 0; a < 2 * PartDepth; a++) begin
      compare_read(a, '0);
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic wait_load_end(input int limit);
    int cnt;
    cnt = 0;
    while (!(done_o || fatal_o)) begin
      if (cnt >= limit) fail_now("Timeout: the load never raised done_o or fatal_o");
      @(posedge clk_i);
      #2;
      cnt++;
    end
  endtask

  task automatic run_load(input int r);
    int flt;
    flt = fault_index(r);
    run = r;
    init_i = 1'b1;
    @(posedge clk_i);
    #2;
    init_i = 1'b0;
    // First request one cycle after init.
    check_bit("otp_req_o", 1'b1, otp_req_o);
    wait_load_end(400);
    check_bit("done_o", (flt == PartDepth), done_o);
    check_bit("fatal_o", (flt != PartDepth), fatal_o);
    check_bit("corr_o", expect_corr(r), corr_o);
    // Reads include the addresses past the end.
    for (int a = 0; a < 2 * PartDepth; a++) begin
      compare_read(a, expect_word(r, a));
    end
    for (int i = 0; i < PartDepth; i++) begin
      check_word($sformatf("part_data_o[%0d]", i), expect_word(r, i), part_data_o[i]);
    end
    // Watch a while for stray requests after the end.
    repeat (12) @(posedge clk_i);
    #2;
    check_word("request count", 64'(flt == PartDepth ? PartDepth : flt + 1), 64'(req_count));
    check_bit("done_o", (flt == PartDepth), done_o);
  endtask

  initial begin
    rst_ni    = 1'b0;
    init_i    = 1'b0;
    rd_addr_i = '0;
    run       = 0;
    apply_reset();
    check_reset_state();
    run_load(0);
    apply_reset();
    check_reset_state();
    run_load(1);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
logic/secded_pkg.sv
logic/otp_part_pkg.sv
logic/secded_enc.sv
logic/secded_dec.sv
logic/otp_ecc_reg.sv
logic/part_loader.sv
logic/part_buf.sv
tests/part_buf_tb.sv

// ==== Makefile ====
# Verilator build and run for the buffered OTP partition.

VERILATOR ?= verilator
TOP       ?= part_buf_tb
FLIST     ?= all.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST RESULT: PASS

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   List the targets."
	@echo "  test   Build with Verilator, run the testbench and check the result."
	@echo "  clean  Remove the build directory."
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR TIMESCALE VFLAGS"

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-f $(FLIST) -Mdir $(BUILD_DIR)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		exit 0; \
	else \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)
